/* playgnd_cfg_pkg.sv */
package playgnd_cfg_pkg;

  // Bus widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  // DMA transfer length in words
  typedef logic [15:0] word_cnt_t;

  //////////////////////////////
  // Slave port address map
  //////////////////////////////

  localparam addr_t DmaCfgBase = 32'h0000_1000;
  localparam addr_t DmaCfgEnd  = 32'h0000_1FFF;
  localparam addr_t TimerBase  = 32'h0000_2000;
  localparam addr_t TimerEnd   = 32'h0000_2FFF;

  // DMA register offsets
  localparam addr_t DmaSrcOff  = 32'h0;
  localparam addr_t DmaDstOff  = 32'h4;
  localparam addr_t DmaLenOff  = 32'h8;
  localparam addr_t DmaCtrlOff = 32'hC;
  localparam addr_t DmaStatOff = 32'h10;

  // Timer register offsets
  localparam addr_t MtimeLoOff    = 32'h0;
  localparam addr_t MtimeHiOff    = 32'h4;
  localparam addr_t MtimecmpLoOff = 32'h8;
  localparam addr_t MtimecmpHiOff = 32'hC;

  // Flops between rtc_i and the edge detector
  localparam int unsigned RtcSyncStages = 2;

endpackage

/* playgnd_axi_pkg.sv */
package playgnd_axi_pkg;

  typedef logic [2:0] prot_t;
  typedef logic [1:0] resp_t;

  localparam resp_t RespOkay   = 2'b00;
  localparam resp_t RespSlvErr = 2'b10;
  localparam resp_t RespDecErr = 2'b11;

  //////////////////////////////
  // AXI4-Lite channels
  //////////////////////////////

  typedef struct packed {
    playgnd_cfg_pkg::addr_t addr;
    prot_t                  prot;
  } axil_aw_t;

  typedef struct packed {
    playgnd_cfg_pkg::data_t data;
    playgnd_cfg_pkg::strb_t strb;
  } axil_w_t;

  typedef struct packed {
    playgnd_cfg_pkg::addr_t addr;
    prot_t                  prot;
  } axil_ar_t;

  typedef struct packed {
    resp_t resp;
  } axil_b_t;

  typedef struct packed {
    playgnd_cfg_pkg::data_t data;
    resp_t                  resp;
  } axil_r_t;

  // Master to slave
  typedef struct packed {
    axil_aw_t aw;
    logic     aw_valid;
    axil_w_t  w;
    logic     w_valid;
    logic     b_ready;
    axil_ar_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axil_req_t;

  // Slave to master
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    axil_b_t b;
    logic    b_valid;
    logic    ar_ready;
    axil_r_t r;
    logic    r_valid;
  } axil_rsp_t;

  // Merge write data into an old word byte by byte
  function automatic playgnd_cfg_pkg::data_t apply_strb(
    input playgnd_cfg_pkg::data_t cur,
    input playgnd_cfg_pkg::data_t wdata,
    input playgnd_cfg_pkg::strb_t strb
  );
    playgnd_cfg_pkg::data_t res;
    res = cur;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return res;
  endfunction

endpackage

/* playgnd_addr_demux.sv */
`timescale 1ns/1ns

module playgnd_addr_demux (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  playgnd_axi_pkg::axil_req_t slv_req_i,
  output playgnd_axi_pkg::axil_rsp_t slv_rsp_o,
  output playgnd_axi_pkg::axil_req_t timer_req_o,
  input  playgnd_axi_pkg::axil_rsp_t timer_rsp_i,
  output playgnd_axi_pkg::axil_req_t dma_req_o,
  input  playgnd_axi_pkg::axil_rsp_t dma_rsp_i
);

  import playgnd_cfg_pkg::*;
  import playgnd_axi_pkg::*;

  typedef enum logic [1:0] {TgtTimer, TgtDma, TgtErr} tgt_e;

  function automatic tgt_e decode(input addr_t addr);
    tgt_e tgt;
    if (addr >= TimerBase && addr <= TimerEnd) begin
      tgt = TgtTimer;
    end else if (addr >= DmaCfgBase && addr <= DmaCfgEnd) begin
      tgt = TgtDma;
    end else begin
      tgt = TgtErr;
    end
    return tgt;
  endfunction

  // Forward only the channels of the selected direction state
  function automatic axil_req_t route(input axil_req_t req, input logic w_hit,
                                      input logic w_busy, input logic r_hit,
                                      input logic r_busy);
    axil_req_t fwd;
    fwd = req;
    fwd.aw_valid = req.aw_valid && w_hit && !w_busy;
    fwd.w_valid  = req.w_valid && w_hit && !w_busy;
    fwd.b_ready  = req.b_ready && w_hit && w_busy;
    fwd.ar_valid = req.ar_valid && r_hit && !r_busy;
    fwd.r_ready  = req.r_ready && r_hit && r_busy;
    return fwd;
  endfunction

  logic      w_busy_q, r_busy_q;
  tgt_e      w_sel_q, r_sel_q;
  tgt_e      aw_tgt, ar_tgt;
  axil_rsp_t w_rsp, r_rsp, err_rsp;

  // Selection holds while a transaction waits for its response
  assign aw_tgt = w_busy_q ? w_sel_q : decode(slv_req_i.aw.addr);
  assign ar_tgt = r_busy_q ? r_sel_q : decode(slv_req_i.ar.addr);

  assign timer_req_o = route(slv_req_i, aw_tgt == TgtTimer, w_busy_q,
                             ar_tgt == TgtTimer, r_busy_q);
  assign dma_req_o   = route(slv_req_i, aw_tgt == TgtDma, w_busy_q,
                             ar_tgt == TgtDma, r_busy_q);

  //////////////////////////////
  // Local decode error slave
  //////////////////////////////

  always_comb begin
    err_rsp          = '0;
    err_rsp.aw_ready = slv_req_i.aw_valid && slv_req_i.w_valid;
    err_rsp.w_ready  = slv_req_i.aw_valid && slv_req_i.w_valid;
    err_rsp.b.resp   = RespDecErr;
    err_rsp.b_valid  = 1'b1;
    err_rsp.ar_ready = 1'b1;
    err_rsp.r.resp   = RespDecErr;
    err_rsp.r_valid  = 1'b1;
  end

  // Response mux
  always_comb begin
    unique case (aw_tgt)
      TgtTimer: w_rsp = timer_rsp_i;
      TgtDma:   w_rsp = dma_rsp_i;
      default:  w_rsp = err_rsp;
    endcase
    unique case (ar_tgt)
      TgtTimer: r_rsp = timer_rsp_i;
      TgtDma:   r_rsp = dma_rsp_i;
      default:  r_rsp = err_rsp;
    endcase
    slv_rsp_o          = '0;
    slv_rsp_o.aw_ready = w_rsp.aw_ready && !w_busy_q;
    slv_rsp_o.w_ready  = w_rsp.w_ready && !w_busy_q;
    slv_rsp_o.b        = w_rsp.b;
    slv_rsp_o.b_valid  = w_rsp.b_valid && w_busy_q;
    slv_rsp_o.ar_ready = r_rsp.ar_ready && !r_busy_q;
    slv_rsp_o.r        = r_rsp.r;
    slv_rsp_o.r_valid  = r_rsp.r_valid && r_busy_q;
  end

  // One outstanding transaction per direction
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      w_busy_q <= 1'b0;
      w_sel_q  <= TgtErr;
      r_busy_q <= 1'b0;
      r_sel_q  <= TgtErr;
    end else begin
      if (slv_req_i.aw_valid && slv_rsp_o.aw_ready) begin
        w_busy_q <= 1'b1;
        w_sel_q  <= aw_tgt;
      end else if (slv_rsp_o.b_valid && slv_req_i.b_ready) begin
        w_busy_q <= 1'b0;
      end
      if (slv_req_i.ar_valid && slv_rsp_o.ar_ready) begin
        r_busy_q <= 1'b1;
        r_sel_q  <= ar_tgt;
      end else if (slv_rsp_o.r_valid && slv_req_i.r_ready) begin
        r_busy_q <= 1'b0;
      end
    end
  end

endmodule

/* playgnd_sys_timer.sv */
`timescale 1ns/1ns

module playgnd_sys_timer (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       rtc_i,
  input  playgnd_axi_pkg::axil_req_t reg_req_i,
  output playgnd_axi_pkg::axil_rsp_t reg_rsp_o,
  output logic                       timer_irq_o
);

  import playgnd_cfg_pkg::*;
  import playgnd_axi_pkg::*;

  logic [RtcSyncStages-1:0] rtc_sync_q;
  logic                     rtc_prev_q;
  logic                     rtc_tick;
  logic [63:0]              mtime_q, mtimecmp_q;
  logic                     irq_q;
  logic                     wr_en, rd_en;
  addr_t                    w_off, r_off;
  logic                     b_valid_q, r_valid_q;
  resp_t                    b_resp_q, r_resp_q;
  data_t                    rd_data, r_data_q;
  logic                     rd_ok;

  //////////////////////////////
  // RTC edge detection
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[RtcSyncStages-2:0], rtc_i};
      rtc_prev_q <= rtc_sync_q[RtcSyncStages-1];
    end
  end

  assign rtc_tick = rtc_sync_q[RtcSyncStages-1] && !rtc_prev_q;

  // Accept write only with both channels present and no B pending
  assign wr_en = reg_req_i.aw_valid && reg_req_i.w_valid && !b_valid_q;
  assign rd_en = reg_req_i.ar_valid && !r_valid_q;
  assign w_off = reg_req_i.aw.addr - TimerBase;
  assign r_off = reg_req_i.ar.addr - TimerBase;

  // A bus write wins over a tick
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '0;
      irq_q      <= 1'b0;
    end else begin
      if (rtc_tick) begin
        mtime_q <= mtime_q + 64'd1;
      end
      if (wr_en) begin
        case (w_off)
          MtimeLoOff:    mtime_q[31:0]     <= apply_strb(mtime_q[31:0],
                                                         reg_req_i.w.data, reg_req_i.w.strb);
          MtimeHiOff:    mtime_q[63:32]    <= apply_strb(mtime_q[63:32],
                                                         reg_req_i.w.data, reg_req_i.w.strb);
          MtimecmpLoOff: mtimecmp_q[31:0]  <= apply_strb(mtimecmp_q[31:0],
                                                         reg_req_i.w.data, reg_req_i.w.strb);
          MtimecmpHiOff: mtimecmp_q[63:32] <= apply_strb(mtimecmp_q[63:32],
                                                         reg_req_i.w.data, reg_req_i.w.strb);
          default: ;
        endcase
      end
      irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  assign timer_irq_o = irq_q;

  // Read mux
  always_comb begin
    rd_ok = 1'b1;
    case (r_off)
      MtimeLoOff:    rd_data = mtime_q[31:0];
      MtimeHiOff:    rd_data = mtime_q[63:32];
      MtimecmpLoOff: rd_data = mtimecmp_q[31:0];
      MtimecmpHiOff: rd_data = mtimecmp_q[63:32];
      default: begin
        rd_data = '0;
        rd_ok   = 1'b0;
      end
    endcase
  end

  //////////////////////////////
  // Response channels
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      b_valid_q <= 1'b0;
      b_resp_q  <= RespOkay;
      r_valid_q <= 1'b0;
      r_resp_q  <= RespOkay;
    end else begin
      if (wr_en) begin
        b_valid_q <= 1'b1;
        b_resp_q  <= (w_off inside {MtimeLoOff, MtimeHiOff, MtimecmpLoOff, MtimecmpHiOff}) ?
                     RespOkay : RespSlvErr;
      end else if (reg_req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_en) begin
        r_valid_q <= 1'b1;
        r_resp_q  <= rd_ok ? RespOkay : RespSlvErr;
      end else if (reg_req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      r_data_q <= rd_data;
    end
  end

  always_comb begin
    reg_rsp_o          = '0;
    reg_rsp_o.aw_ready = wr_en;
    reg_rsp_o.w_ready  = wr_en;
    reg_rsp_o.b.resp   = b_resp_q;
    reg_rsp_o.b_valid  = b_valid_q;
    reg_rsp_o.ar_ready = !r_valid_q;
    reg_rsp_o.r.data   = r_data_q;
    reg_rsp_o.r.resp   = r_resp_q;
    reg_rsp_o.r_valid  = r_valid_q;
  end

endmodule

/* playgnd_traffic_dma.sv */
`timescale 1ns/1ns

module playgnd_traffic_dma (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  playgnd_axi_pkg::axil_req_t cfg_req_i,
  output playgnd_axi_pkg::axil_rsp_t cfg_rsp_o,
  output playgnd_axi_pkg::axil_req_t mst_req_o,
  input  playgnd_axi_pkg::axil_rsp_t mst_rsp_i
);

  import playgnd_cfg_pkg::*;
  import playgnd_axi_pkg::*;

  typedef enum logic [2:0] {
    DmaIdle, DmaReadAddr, DmaReadData, DmaWrite, DmaWriteResp
  } dma_state_e;

  dma_state_e state_q;
  addr_t      src_q, dst_q, rd_addr_q, wr_addr_q;
  word_cnt_t  len_q, xfer_len_q, count_q, len_wr;
  data_t      buf_q, rd_data, r_data_q;
  logic       err_q, busy, start;
  logic       aw_done_q, w_done_q;
  logic       wr_en, rd_en, rd_ok, wr_ok;
  addr_t      w_off, r_off;
  logic       b_valid_q, r_valid_q;
  resp_t      b_resp_q, r_resp_q;

  //////////////////////////////
  // Config registers
  //////////////////////////////

  assign wr_en  = cfg_req_i.aw_valid && cfg_req_i.w_valid && !b_valid_q;
  assign rd_en  = cfg_req_i.ar_valid && !r_valid_q;
  assign w_off  = cfg_req_i.aw.addr - DmaCfgBase;
  assign r_off  = cfg_req_i.ar.addr - DmaCfgBase;
  assign busy   = (state_q != DmaIdle);
  assign len_wr = word_cnt_t'(apply_strb(data_t'(len_q), cfg_req_i.w.data, cfg_req_i.w.strb));
  assign wr_ok  = w_off inside {DmaSrcOff, DmaDstOff, DmaLenOff, DmaCtrlOff};

  // Start request dropped while a copy runs
  assign start = wr_en && (w_off == DmaCtrlOff) && cfg_req_i.w.strb[0] &&
                 cfg_req_i.w.data[0] && !busy;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      src_q <= '0;
      dst_q <= '0;
      len_q <= '0;
    end else if (wr_en) begin
      case (w_off)
        DmaSrcOff: src_q <= apply_strb(src_q, cfg_req_i.w.data, cfg_req_i.w.strb);
        DmaDstOff: dst_q <= apply_strb(dst_q, cfg_req_i.w.data, cfg_req_i.w.strb);
        DmaLenOff: len_q <= len_wr;
        default: ;
      endcase
    end
  end

  always_comb begin
    rd_ok = 1'b1;
    case (r_off)
      DmaSrcOff:  rd_data = src_q;
      DmaDstOff:  rd_data = dst_q;
      DmaLenOff:  rd_data = data_t'(len_q);
      DmaCtrlOff: rd_data = '0;
      DmaStatOff: rd_data = {count_q, 14'b0, err_q, busy};
      default: begin
        rd_data = '0;
        rd_ok   = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      b_valid_q <= 1'b0;
      b_resp_q  <= RespOkay;
      r_valid_q <= 1'b0;
      r_resp_q  <= RespOkay;
    end else begin
      if (wr_en) begin
        b_valid_q <= 1'b1;
        b_resp_q  <= wr_ok ? RespOkay : RespSlvErr;
      end else if (cfg_req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_en) begin
        r_valid_q <= 1'b1;
        r_resp_q  <= rd_ok ? RespOkay : RespSlvErr;
      end else if (cfg_req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_comb begin
    cfg_rsp_o          = '0;
    cfg_rsp_o.aw_ready = wr_en;
    cfg_rsp_o.w_ready  = wr_en;
    cfg_rsp_o.b.resp   = b_resp_q;
    cfg_rsp_o.b_valid  = b_valid_q;
    cfg_rsp_o.ar_ready = !r_valid_q;
    cfg_rsp_o.r.data   = r_data_q;
    cfg_rsp_o.r.resp   = r_resp_q;
    cfg_rsp_o.r_valid  = r_valid_q;
  end

  //////////////////////////////
  // Copy engine
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= DmaIdle;
      rd_addr_q  <= '0;
      wr_addr_q  <= '0;
      xfer_len_q <= '0;
      count_q    <= '0;
      err_q      <= 1'b0;
      aw_done_q  <= 1'b0;
      w_done_q   <= 1'b0;
    end else begin
      unique case (state_q)
        DmaIdle: begin
          if (start) begin
            rd_addr_q  <= src_q;
            wr_addr_q  <= dst_q;
            xfer_len_q <= len_q;
            count_q    <= '0;
            err_q      <= 1'b0;
            // Zero length never leaves idle
            state_q    <= (len_q == '0) ? DmaIdle : DmaReadAddr;
          end
        end
        DmaReadAddr: begin
          if (mst_rsp_i.ar_ready) begin
            state_q <= DmaReadData;
          end
        end
        DmaReadData: begin
          if (mst_rsp_i.r_valid) begin
            if (mst_rsp_i.r.resp != RespOkay) begin
              err_q   <= 1'b1;
              state_q <= DmaIdle;
            end else begin
              aw_done_q <= 1'b0;
              w_done_q  <= 1'b0;
              state_q   <= DmaWrite;
            end
          end
        end
        DmaWrite: begin
          // AW and W may be taken on different edges
          if (mst_rsp_i.aw_ready) begin
            aw_done_q <= 1'b1;
          end
          if (mst_rsp_i.w_ready) begin
            w_done_q <= 1'b1;
          end
          if ((aw_done_q || mst_rsp_i.aw_ready) && (w_done_q || mst_rsp_i.w_ready)) begin
            state_q <= DmaWriteResp;
          end
        end
        DmaWriteResp: begin
          if (mst_rsp_i.b_valid) begin
            if (mst_rsp_i.b.resp != RespOkay) begin
              err_q   <= 1'b1;
              state_q <= DmaIdle;
            end else begin
              count_q   <= count_q + 16'd1;
              rd_addr_q <= rd_addr_q + 32'd4;
              wr_addr_q <= wr_addr_q + 32'd4;
              state_q   <= (count_q + 16'd1 == xfer_len_q) ? DmaIdle : DmaReadAddr;
            end
          end
        end
        default: state_q <= DmaIdle;
      endcase
    end
  end

  // Data words
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      r_data_q <= rd_data;
    end
    if (state_q == DmaReadData && mst_rsp_i.r_valid) begin
      buf_q <= mst_rsp_i.r.data;
    end
  end

  always_comb begin
    mst_req_o          = '0;
    mst_req_o.ar.addr  = rd_addr_q;
    mst_req_o.ar_valid = (state_q == DmaReadAddr);
    mst_req_o.r_ready  = (state_q == DmaReadData);
    mst_req_o.aw.addr  = wr_addr_q;
    mst_req_o.aw_valid = (state_q == DmaWrite) && !aw_done_q;
    mst_req_o.w.data   = buf_q;
    mst_req_o.w.strb   = '1;
    mst_req_o.w_valid  = (state_q == DmaWrite) && !w_done_q;
    mst_req_o.b_ready  = (state_q == DmaWriteResp);
  end

endmodule

/* playgnd_top.sv */
`timescale 1ns/1ns

module playgnd_top (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       rtc_i,
  input  playgnd_axi_pkg::axil_req_t slv_req_i,
  output playgnd_axi_pkg::axil_rsp_t slv_rsp_o,
  output playgnd_axi_pkg::axil_req_t dma_mst_req_o,
  input  playgnd_axi_pkg::axil_rsp_t dma_mst_rsp_i,
  output logic                       timer_irq_o
);

  import playgnd_axi_pkg::*;

  // Demux to register blocks
  axil_req_t timer_req, dma_cfg_req;
  axil_rsp_t timer_rsp, dma_cfg_rsp;

  playgnd_addr_demux i_addr_demux (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .slv_req_i   ( slv_req_i   ),
    .slv_rsp_o   ( slv_rsp_o   ),
    .timer_req_o ( timer_req   ),
    .timer_rsp_i ( timer_rsp   ),
    .dma_req_o   ( dma_cfg_req ),
    .dma_rsp_i   ( dma_cfg_rsp )
  );

  playgnd_sys_timer i_sys_timer (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .rtc_i       ( rtc_i       ),
    .reg_req_i   ( timer_req   ),
    .reg_rsp_o   ( timer_rsp   ),
    .timer_irq_o ( timer_irq_o )
  );

  playgnd_traffic_dma i_traffic_dma (
    .clk_i     ( clk_i         ),
    .arst_n_i  ( arst_n_i      ),
    .cfg_req_i ( dma_cfg_req   ),
    .cfg_rsp_o ( dma_cfg_rsp   ),
    .mst_req_o ( dma_mst_req_o ),
    .mst_rsp_i ( dma_mst_rsp_i )
  );

endmodule

/* playgnd_top_assert.sv */
`timescale 1ns/1ns

module playgnd_top_assert (
  input logic                       clk_i,
  input logic                       arst_n_i,
  input playgnd_axi_pkg::axil_req_t slv_req_i,
  input playgnd_axi_pkg::axil_rsp_t slv_rsp_i,
  input playgnd_axi_pkg::axil_req_t mst_req_i,
  input playgnd_axi_pkg::axil_rsp_t mst_rsp_i
);

  //////////////////////////////
  // Valid held until ready
  //////////////////////////////

  slv_b_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    slv_rsp_i.b_valid && !slv_req_i.b_ready |=> slv_rsp_i.b_valid && $stable(slv_rsp_i.b))
    else $error("Slave port B dropped or changed before b_ready");

  slv_r_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    slv_rsp_i.r_valid && !slv_req_i.r_ready |=> slv_rsp_i.r_valid && $stable(slv_rsp_i.r))
    else $error("Slave port R dropped or changed before r_ready");

  mst_ar_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mst_req_i.ar_valid && !mst_rsp_i.ar_ready |=> mst_req_i.ar_valid && $stable(mst_req_i.ar))
    else $error("DMA AR dropped or changed before ar_ready");

  mst_aw_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mst_req_i.aw_valid && !mst_rsp_i.aw_ready |=> mst_req_i.aw_valid && $stable(mst_req_i.aw))
    else $error("DMA AW dropped or changed before aw_ready");

  mst_w_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mst_req_i.w_valid && !mst_rsp_i.w_ready |=> mst_req_i.w_valid && $stable(mst_req_i.w))
    else $error("DMA W dropped or changed before w_ready");

  // Quiet outputs in reset
  reset_quiet_a: assert property (@(posedge clk_i)
    !arst_n_i |-> !(slv_rsp_i.b_valid || slv_rsp_i.r_valid || mst_req_i.ar_valid ||
                    mst_req_i.aw_valid || mst_req_i.w_valid))
    else $error("Valid output high during reset");

  // Register blocks take AW and W on the same edge
  aw_with_w_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    slv_req_i.aw_valid && slv_rsp_i.aw_ready |-> slv_req_i.w_valid && slv_rsp_i.w_ready)
    else $error("Slave port accepted AW without its W");

endmodule

bind playgnd_top playgnd_top_assert i_top_assert (
  .clk_i     ( clk_i         ),
  .arst_n_i  ( arst_n_i      ),
  .slv_req_i ( slv_req_i     ),
  .slv_rsp_i ( slv_rsp_o     ),
  .mst_req_i ( dma_mst_req_o ),
  .mst_rsp_i ( dma_mst_rsp_i )
);

/* tb_playgnd_top.sv */
`timescale 1ns/1ns

module tb_playgnd_top;

  import playgnd_cfg_pkg::*;
  import playgnd_axi_pkg::*;

  localparam int RspTimeout = 50;
  // Tests take about 2000 cycles at the longest memory delays
  localparam int MaxCycles  = 20000;
  localparam addr_t SrcBuf  = 32'h0000_4000;
  localparam addr_t DstBuf  = 32'h0000_8000;
  // Memory answers with a slave error from here up
  localparam addr_t ErrBase = 32'h0000_E000;

  logic      clk;
  logic      arst_n;
  logic      rtc;
  logic      irq;
  axil_req_t slv_req;
  axil_rsp_t slv_rsp;
  axil_req_t mst_req;
  axil_rsp_t mst_rsp;

  logic [15:0] lfsr_state = 16'd39;
  data_t       mem [addr_t];
  int          mem_reads  = 0;
  int          mem_writes = 0;
  int          cycles     = 0;
  data_t       exp_src, exp_dst, exp_len, exp_cmp_lo, exp_cmp_hi;

  playgnd_top DUT (
    .clk_i         ( clk     ),
    .arst_n_i      ( arst_n  ),
    .rtc_i         ( rtc     ),
    .slv_req_i     ( slv_req ),
    .slv_rsp_o     ( slv_rsp ),
    .dma_mst_req_o ( mst_req ),
    .dma_mst_rsp_i ( mst_rsp ),
    .timer_irq_o   ( irq     )
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      abort_run($sformatf("Run exceeded the limit of %0d cycles", MaxCycles));
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check(input string test, input data_t exp, input data_t act);
    if (exp !== act) begin
      abort_run($sformatf("CHECK FAILED %s: expected 0x%08h, actual 0x%08h", test, exp, act));
    end
  endtask

  task automatic stall_guard(inout int n, input string what);
    n++;
    if (n > RspTimeout) begin
      abort_run($sformatf("Timeout while waiting for %s", what));
    end
  endtask

  // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic data_t rand_bits(input int n);
    data_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // Busy bit 0, error bit 1, words copied in 31:16
  function automatic data_t status_word(input word_cnt_t count, input logic err);
    return {count, 14'b0, err, 1'b0};
  endfunction

  //////////////////////////////
  // Slave port master
  //////////////////////////////

  task automatic axil_write(input addr_t addr, input data_t data, output resp_t resp);
    int n;
    @(posedge clk);
    slv_req.aw.addr  <= addr;
    slv_req.w.data   <= data;
    slv_req.w.strb   <= '1;
    slv_req.aw_valid <= 1'b1;
    slv_req.w_valid  <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      stall_guard(n, "AW and W ready on the slave port");
    end while (!(slv_rsp.aw_ready && slv_rsp.w_ready));
    @(posedge clk);
    slv_req.aw_valid <= 1'b0;
    slv_req.w_valid  <= 1'b0;
    slv_req.b_ready  <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      stall_guard(n, "B valid on the slave port");
    end while (!slv_rsp.b_valid);
    resp = slv_rsp.b.resp;
    @(posedge clk);
    slv_req.b_ready <= 1'b0;
  endtask

  task automatic axil_read(input addr_t addr, output data_t data, output resp_t resp);
    int n;
    @(posedge clk);
    slv_req.ar.addr  <= addr;
    slv_req.ar_valid <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      stall_guard(n, "AR ready on the slave port");
    end while (!slv_rsp.ar_ready);
    @(posedge clk);
    slv_req.ar_valid <= 1'b0;
    slv_req.r_ready  <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      stall_guard(n, "R valid on the slave port");
    end while (!slv_rsp.r_valid);
    data = slv_rsp.r.data;
    resp = slv_rsp.r.resp;
    @(posedge clk);
    slv_req.r_ready <= 1'b0;
  endtask

  task automatic write_ok(input string test, input addr_t addr, input data_t data);
    resp_t resp;
    axil_write(addr, data, resp);
    check(test, data_t'(RespOkay), data_t'(resp));
  endtask

  task automatic read_expect(input string test, input addr_t addr, input data_t exp);
    data_t data;
    resp_t resp;
    axil_read(addr, data, resp);
    check(test, data_t'(RespOkay), data_t'(resp));
    check(test, exp, data);
  endtask

  //////////////////////////////
  // Memory on the DMA port
  //////////////////////////////

  function automatic data_t mem_word(input addr_t a);
    return mem.exists(a) ? mem[a] : (a ^ 32'h5A5A_C3C3);
  endfunction

  always begin : mem_read_port
    addr_t a;
    int    d;
    @(negedge clk);
    if (mst_req.ar_valid) begin
      a = mst_req.ar.addr;
      d = rand_bits(2);
      repeat (d) @(posedge clk);
      @(posedge clk);
      mst_rsp.ar_ready <= 1'b1;
      @(posedge clk);
      mst_rsp.ar_ready <= 1'b0;
      mem_reads++;
      d = rand_bits(2);
      repeat (d) @(posedge clk);
      mst_rsp.r.data  <= (a >= ErrBase) ? '0 : mem_word(a);
      mst_rsp.r.resp  <= (a >= ErrBase) ? RespSlvErr : RespOkay;
      mst_rsp.r_valid <= 1'b1;
      do begin
        @(negedge clk);
      end while (!mst_req.r_ready);
      @(posedge clk);
      mst_rsp.r_valid <= 1'b0;
    end
  end

  always begin : mem_write_port
    addr_t a;
    data_t wd;
    int    da;
    int    dw;
    @(negedge clk);
    if (mst_req.aw_valid && mst_req.w_valid) begin
      a  = mst_req.aw.addr;
      wd = mst_req.w.data;
      // The copy engine moves whole words
      check("mem_write_port", 32'h0000_000F, data_t'(mst_req.w.strb));
      da = rand_bits(2);
      dw = rand_bits(2);
      // AW and W ready pulse on independent cycles
      for (int c = 0; c <= 4; c++) begin
        @(posedge clk);
        mst_rsp.aw_ready <= (c == da);
        mst_rsp.w_ready  <= (c == dw);
      end
      mem_writes++;
      if (a < ErrBase) begin
        mem[a] = wd;
      end
      mst_rsp.b.resp  <= (a >= ErrBase) ? RespSlvErr : RespOkay;
      mst_rsp.b_valid <= 1'b1;
      do begin
        @(negedge clk);
      end while (!mst_req.b_ready);
      @(posedge clk);
      mst_rsp.b_valid <= 1'b0;
    end
  end

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic after_reset();
    repeat (9) @(posedge clk);
    @(negedge clk);
    check("after_reset", 32'd0, data_t'(irq));
    check("after_reset", 32'd0, data_t'({mst_req.ar_valid, mst_req.aw_valid, mst_req.w_valid}));
    @(posedge clk);
    arst_n <= 1'b1;
    // mtimecmp is zero so the interrupt follows release
    repeat (2) @(negedge clk);
    check("after_reset", 32'd1, data_t'(irq));
  endtask

  task automatic check_regs(input string test);
    read_expect(test, DmaCfgBase + DmaSrcOff, exp_src);
    read_expect(test, DmaCfgBase + DmaDstOff, exp_dst);
    read_expect(test, DmaCfgBase + DmaLenOff, exp_len);
    read_expect(test, TimerBase + MtimecmpLoOff, exp_cmp_lo);
    read_expect(test, TimerBase + MtimecmpHiOff, exp_cmp_hi);
  endtask

  task automatic reg_readback();
    data_t len_raw;
    exp_src    = rand_bits(32);
    exp_dst    = rand_bits(32);
    len_raw    = rand_bits(32);
    exp_len    = {16'h0, len_raw[15:0]};
    exp_cmp_lo = rand_bits(32);
    exp_cmp_hi = rand_bits(32);
    write_ok("reg_readback", DmaCfgBase + DmaSrcOff, exp_src);
    write_ok("reg_readback", DmaCfgBase + DmaDstOff, exp_dst);
    write_ok("reg_readback", DmaCfgBase + DmaLenOff, len_raw);
    write_ok("reg_readback", TimerBase + MtimecmpLoOff, exp_cmp_lo);
    write_ok("reg_readback", TimerBase + MtimecmpHiOff, exp_cmp_hi);
    check_regs("reg_readback");
  endtask

  task automatic decode_error();
    addr_t bad [3];
    data_t data;
    resp_t resp;
    bad = '{32'h0000_0000, 32'h0000_3000, 32'h0001_0000};
    foreach (bad[i]) begin
      axil_write(bad[i], rand_bits(32), resp);
      check("decode_error", data_t'(RespDecErr), data_t'(resp));
      axil_read(bad[i], data, resp);
      check("decode_error", data_t'(RespDecErr), data_t'(resp));
      check("decode_error", 32'd0, data);
    end
    check_regs("decode_error");
  endtask

  task automatic wait_dma_idle(input string test, output data_t stat);
    resp_t resp;
    int    polls;
    polls = 0;
    do begin
      axil_read(DmaCfgBase + DmaStatOff, stat, resp);
      check(test, data_t'(RespOkay), data_t'(resp));
      polls++;
      if (polls > 200) begin
        abort_run("DMA stayed busy for more than 200 status polls");
      end
    end while (stat[0]);
  endtask

  task automatic dma_copy();
    data_t src_words [8];
    data_t stat;
    int    reads0;
    int    writes0;
    for (int i = 0; i < 8; i++) begin
      src_words[i] = rand_bits(32);
      mem[SrcBuf + addr_t'(4 * i)] = src_words[i];
    end
    reads0  = mem_reads;
    writes0 = mem_writes;
    write_ok("dma_copy", DmaCfgBase + DmaSrcOff, SrcBuf);
    write_ok("dma_copy", DmaCfgBase + DmaDstOff, DstBuf);
    write_ok("dma_copy", DmaCfgBase + DmaLenOff, 32'd8);
    write_ok("dma_copy", DmaCfgBase + DmaCtrlOff, 32'd1);
    // Second start lands mid-transfer
    write_ok("dma_copy", DmaCfgBase + DmaCtrlOff, 32'd1);
    wait_dma_idle("dma_copy", stat);
    check("dma_copy", status_word(16'd8, 1'b0), stat);
    for (int i = 0; i < 8; i++) begin
      check("dma_copy", src_words[i], mem_word(DstBuf + addr_t'(4 * i)));
    end
    check("dma_copy", 32'd8, data_t'(mem_reads - reads0));
    check("dma_copy", 32'd8, data_t'(mem_writes - writes0));
  endtask

  task automatic dma_error();
    data_t stat;
    write_ok("dma_error", DmaCfgBase + DmaSrcOff, ErrBase);
    write_ok("dma_error", DmaCfgBase + DmaDstOff, DstBuf + 32'h100);
    write_ok("dma_error", DmaCfgBase + DmaLenOff, 32'd4);
    write_ok("dma_error", DmaCfgBase + DmaCtrlOff, 32'd1);
    wait_dma_idle("dma_error", stat);
    check("dma_error", status_word(16'd0, 1'b1), stat);
  endtask

  task automatic dma_zero_len();
    data_t stat;
    int    reads0;
    int    writes0;
    reads0  = mem_reads;
    writes0 = mem_writes;
    write_ok("dma_zero_len", DmaCfgBase + DmaSrcOff, SrcBuf);
    write_ok("dma_zero_len", DmaCfgBase + DmaLenOff, 32'd0);
    write_ok("dma_zero_len", DmaCfgBase + DmaCtrlOff, 32'd1);
    wait_dma_idle("dma_zero_len", stat);
    check("dma_zero_len", status_word(16'd0, 1'b0), stat);
    repeat (10) @(posedge clk);
    check("dma_zero_len", data_t'(reads0), data_t'(mem_reads));
    check("dma_zero_len", data_t'(writes0), data_t'(mem_writes));
  endtask

  // One slow RTC period that the synchronizer settles within
  task automatic rtc_edge();
    @(posedge clk);
    rtc <= 1'b1;
    repeat (4) @(posedge clk);
    rtc <= 1'b0;
    repeat (4) @(posedge clk);
  endtask

  task automatic timer_count();
    // Leave mtime nonzero so the clear below has an effect
    rtc_edge();
    write_ok("timer_count", TimerBase + MtimeLoOff, 32'd0);
    write_ok("timer_count", TimerBase + MtimeHiOff, 32'd0);
    write_ok("timer_count", TimerBase + MtimecmpHiOff, 32'd0);
    write_ok("timer_count", TimerBase + MtimecmpLoOff, 32'd5);
    @(negedge clk);
    check("timer_count", 32'd0, data_t'(irq));
    repeat (4) rtc_edge();
    read_expect("timer_count", TimerBase + MtimeLoOff, 32'd4);
    read_expect("timer_count", TimerBase + MtimeHiOff, 32'd0);
    @(negedge clk);
    check("timer_count", 32'd0, data_t'(irq));
    rtc_edge();
    @(negedge clk);
    check("timer_count", 32'd1, data_t'(irq));
    write_ok("timer_count", TimerBase + MtimecmpLoOff, 32'd100);
    @(negedge clk);
    check("timer_count", 32'd0, data_t'(irq));
  endtask

  initial begin
    clk     = 1'b0;
    arst_n  = 1'b0;
    rtc     = 1'b0;
    slv_req = '0;
    mst_rsp = '0;
    after_reset();
    reg_readback();
    decode_error();
    dma_copy();
    dma_error();
    dma_zero_len();
    timer_count();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* playgnd_top.f */
playgnd_cfg_pkg.sv
playgnd_axi_pkg.sv
playgnd_addr_demux.sv
playgnd_sys_timer.sv
playgnd_traffic_dma.sv
playgnd_top.sv
playgnd_top_assert.sv
tb_playgnd_top.sv

/* Makefile */
TOP := tb_playgnd_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f playgnd_top.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' sim.log || (echo "Simulation did not finish"; exit 1)

lint:
	verilator --lint-only -Wall --timing --assert -f playgnd_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
